// File: build.f
verilog/cpuPkg.sv
verilog/aluUnit.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/cpuTop.sv
dv/cpuTb.sv

// File: dv/cpuTb.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTb
  import cpuPkg::*;
();

  logic clk;
  logic reset;
  logic progWrEn;
  logic [imemIdxBits-1:0] progAddr;
  logic [dataBits-1:0] progData;
  logic [swBits-1:0] sw;
  logic [hexBits-1:0] hex;
  logic [ledrBits-1:0] ledr;

  logic [31:0] rngState = 32'h75bca9e1;
  logic [31:0] prog[$];
  logic [33:0] expected[$];
  logic [33:0] seen[$];
  logic [33:0] lastOut;
  logic [31:0] mReg [regWords];
  logic [31:0] mDmem [dmemWords];
  logic [23:0] finalHex;
  logic [9:0] finalLedr;
  int errors;
  int testsRun;
  int testsFailed;

  cpuTop uut (
    .clk(clk),
    .reset(reset),
    .progWrEn(progWrEn),
    .progAddr(progAddr),
    .progData(progData),
    .sw(sw),
    .hex(hex),
    .ledr(ledr)
  );

  always #2 clk = ~clk;

  // records each visible change of hex or ledr at the falling edge
  always @(negedge clk) begin
    if (!reset && {hex, ledr} !== lastOut) begin
      seen.push_back({hex, ledr});
      lastOut = {hex, ledr};
    end
  end

  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  function automatic logic [13:0] randImm();
    logic [31:0] v;
    v = nextRand();
    return v[26:13];
  endfunction

  // sources may use r1 which stays zero
  function automatic logic [5:0] srcReg();
    logic [31:0] v;
    v = nextRand();
    return 6'(1 + v[31:16] % 8);
  endfunction

  function automatic logic [5:0] dstReg();
    logic [31:0] v;
    v = nextRand();
    return 6'(2 + v[31:16] % 7);
  endfunction

  function automatic logic [31:0] regOp(input aluFuncT f, input logic [5:0] rd,
      input logic [5:0] rs, input logic [5:0] rt);
    return {opAlur, rs, rt, rd, 2'b00, f};
  endfunction

  function automatic logic [31:0] immOp(input opcode1T op, input logic [5:0] rs,
      input logic [5:0] rt, input logic [13:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // store rt to an absolute address through base r1
  function automatic logic [31:0] storeOp(input logic [5:0] rt, input logic [31:0] addr);
    return immOp(opSw, 6'd1, rt, addr[13:0]);
  endfunction

  function automatic logic [31:0] refAlu(input logic [5:0] f, input logic [31:0] a,
      input logic [31:0] b);
    case (f)
      aluEq: return {31'd0, $signed(a) == $signed(b)};
      aluLt: return {31'd0, $signed(a) < $signed(b)};
      aluLe: return {31'd0, $signed(a) <= $signed(b)};
      aluNe: return {31'd0, $signed(a) != $signed(b)};
      aluAdd: return a + b;
      aluSub: return a - b;
      aluAnd: return a & b;
      aluOr: return a | b;
      aluXor: return a ^ b;
      aluNand: return ~(a & b);
      aluNor: return ~(a | b);
      aluNxor: return ~(a ^ b);
      default: return 32'd0;
    endcase
  endfunction

  task automatic buildProgram();
    aluFuncT funcs [12];
    opcode1T immOps [4];
    opcode1T brOps [5];
    logic [5:0] r;
    logic [5:0] s;
    logic [13:0] v;
    logic [13:0] dAddr;
    int here;
    funcs = '{aluEq, aluLt, aluLe, aluNe, aluAdd, aluSub, aluAnd, aluOr, aluXor,
              aluNand, aluNor, aluNxor};
    immOps = '{opAddi, opAndi, opOri, opXori};
    brOps = '{opBeq, opBne, opBlt, opBle, opBne};
    // r1 is cleared first and serves as the base for every address
    prog.push_back(immOp(opAndi, 6'd1, 6'd1, 14'd0));
    for (int k = 2; k <= 8; k++) begin
      prog.push_back(immOp(opAddi, 6'd1, 6'(k), randImm()));
    end
    // each result is stored right away to force a back-to-back hazard
    for (int i = 0; i < 12; i++) begin
      r = dstReg();
      prog.push_back(regOp(funcs[i], r, srcReg(), srcReg()));
      prog.push_back(storeOp(r, (i % 2 == 1) ? addrLedr : addrHex));
    end
    for (int i = 0; i < 4; i++) begin
      r = dstReg();
      prog.push_back(immOp(immOps[i], srcReg(), r, randImm()));
      prog.push_back(storeOp(r, addrHex));
    end
    // data memory round trip followed by switch and LED reads
    v = randImm();
    dAddr = {2'b00, v[9:0], 2'b00};
    r = dstReg();
    prog.push_back(immOp(opSw, 6'd1, srcReg(), dAddr));
    prog.push_back(immOp(opLw, 6'd1, r, dAddr));
    prog.push_back(storeOp(r, addrHex));
    r = dstReg();
    prog.push_back(immOp(opLw, 6'd1, r, addrSw[13:0]));
    prog.push_back(storeOp(r, addrHex));
    r = dstReg();
    prog.push_back(immOp(opLw, 6'd1, r, addrLedr[13:0]));
    prog.push_back(storeOp(r, addrHex));
    // forward branches over two stores
    // the first two compare a register with itself
    for (int i = 0; i < 5; i++) begin
      r = srcReg();
      s = (i < 2) ? r : srcReg();
      prog.push_back(immOp(brOps[i], r, s, 14'd2));
      prog.push_back(storeOp(dstReg(), addrHex));
      prog.push_back(storeOp(dstReg(), addrLedr));
    end
    // jal off r1 is an absolute word target
    here = prog.size();
    r = dstReg();
    prog.push_back(immOp(opJal, 6'd1, r, 14'((startPc >> 2) + here + 3)));
    prog.push_back(storeOp(srcReg(), addrHex));
    prog.push_back(storeOp(srcReg(), addrLedr));
    prog.push_back(storeOp(r, addrHex));
    // park on a branch to itself with nops behind it
    prog.push_back(immOp(opBeq, 6'd1, 6'd1, 14'h3fff));
    repeat (4) prog.push_back(32'd0);
  endtask

  task automatic runModel();
    logic [31:0] pc;
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] off;
    logic [31:0] addr;
    logic [31:0] nextPc;
    logic [5:0] rt;
    logic [23:0] curHex;
    logic [9:0] curLedr;
    logic taken;
    int steps;
    pc = startPc;
    curHex = hexResetVal;
    curLedr = '0;
    steps = 0;
    while (steps < 1000) begin
      inst = prog[(pc - startPc) >> 2];
      a = mReg[inst[25:20]];
      b = mReg[inst[19:14]];
      rt = inst[19:14];
      off = {{18{inst[13]}}, inst[13:0]};
      addr = a + off;
      nextPc = pc + 4;
      taken = 1'b0;
      case (inst[31:26])
        opAlur: begin
          if (inst[5:0] != aluNop && inst[5:0] != aluJalr) begin
            mReg[inst[13:8]] = refAlu(inst[5:0], a, b);
          end
        end
        opAddi: mReg[rt] = a + off;
        opAndi: mReg[rt] = a & off;
        opOri: mReg[rt] = a | off;
        opXori: mReg[rt] = a ^ off;
        opBeq: taken = (a == b);
        opBne: taken = (a != b);
        opBlt: taken = ($signed(a) < $signed(b));
        opBle: taken = ($signed(a) <= $signed(b));
        opJal: begin
          mReg[rt] = pc + 4;
          nextPc = a + (off << 2);
        end
        opLw: begin
          if (addr[31:12] == 20'd0) begin
            mReg[rt] = mDmem[addr[11:2]];
          end else if (addr == addrSw) begin
            mReg[rt] = {22'd0, sw};
          end else if (addr == addrHex) begin
            mReg[rt] = {8'd0, curHex};
          end else if (addr == addrLedr) begin
            mReg[rt] = {22'd0, curLedr};
          end else begin
            mReg[rt] = 32'd0;
          end
        end
        opSw: begin
          if (addr[31:12] == 20'd0) begin
            mDmem[addr[11:2]] = b;
          end
          if (addr == addrHex && b[23:0] != curHex) begin
            curHex = b[23:0];
            expected.push_back({curHex, curLedr});
          end
          if (addr == addrLedr && b[9:0] != curLedr) begin
            curLedr = b[9:0];
            expected.push_back({curHex, curLedr});
          end
        end
        default: ;
      endcase
      if (taken) begin
        nextPc = pc + 4 + (off << 2);
      end
      // the closing branch to itself ends the program
      steps = (nextPc == pc) ? 1000 : steps + 1;
      pc = nextPc;
    end
    finalHex = curHex;
    finalLedr = curLedr;
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
      input logic [31:0] exp);
    assert (got === exp)
      else begin
        $display("Fail %s: got %h, expected %h", name, got, exp);
        errors++;
      end
  endtask

  task automatic reportTest(input string name, input int errsBefore);
    testsRun++;
    if (errors == errsBefore) begin
      $display("%s: pass", name);
    end else begin
      testsFailed++;
      $display("%s: %0d errors", name, errors - errsBefore);
    end
  endtask

  initial begin
    logic [31:0] v;
    logic [33:0] got;
    logic [33:0] want;
    int mark;
    int loadCycles;
    int waitCycles;
    clk = 1'b0;
    reset = 1'b1;
    progWrEn = 1'b0;
    progAddr = '0;
    progData = '0;
    lastOut = {hexResetVal, 10'd0};
    errors = 0;
    testsRun = 0;
    testsFailed = 0;
    v = nextRand();
    sw = v[25:16];
    buildProgram();
    runModel();

    // reset lasts at least 16 cycles and covers the whole load
    loadCycles = (prog.size() > 16) ? prog.size() : 16;
    mark = errors;
    for (int i = 0; i < loadCycles; i++) begin
      @(posedge clk);
      #1;
      progWrEn = (i < prog.size());
      progAddr = imemIdxBits'((startPc >> 2) + i);
      progData = (i < prog.size()) ? prog[i] : 32'd0;
      checkValue("hex", 32'(hex), 32'(hexResetVal));
      checkValue("ledr", 32'(ledr), 32'd0);
    end
    @(posedge clk);
    #1;
    progWrEn = 1'b0;
    reset = 1'b0;
    reportTest("reset values", mark);

    mark = errors;
    waitCycles = 0;
    while (seen.size() < expected.size() && waitCycles < 4000) begin
      @(posedge clk);
      waitCycles++;
    end
    assert (seen.size() >= expected.size())
      else begin
        $display("timed out after 4000 cycles with %0d of %0d output changes",
                 seen.size(), expected.size());
        errors++;
      end
    // no further change may show up while the core spins on its last branch
    repeat (40) @(posedge clk);
    assert (seen.size() == expected.size())
      else begin
        $display("saw %0d output changes but the model made %0d",
                 seen.size(), expected.size());
        errors++;
      end
    reportTest("change count", mark);

    mark = errors;
    for (int i = 0; i < expected.size() && i < seen.size(); i++) begin
      got = seen[i];
      want = expected[i];
      checkValue($sformatf("hex change %0d", i), 32'(got[33:10]), 32'(want[33:10]));
      checkValue($sformatf("ledr change %0d", i), 32'(got[9:0]), 32'(want[9:0]));
    end
    reportTest("store sequence", mark);

    @(negedge clk);
    mark = errors;
    checkValue("hex", 32'(hex), 32'(finalHex));
    checkValue("ledr", 32'(ledr), 32'(finalLedr));
    reportTest("final outputs", mark);

    $display("%0d tests run, %0d failed, %0d check errors", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f build.f --top-module cpuTb \
  -o cpuSim > sim.log 2>&1 \
  && ./obj_dir/cpuSim >> sim.log 2>&1 \
  && ! grep -q "Test FAILED" sim.log \
  && echo "simulation passed" \
  || { cat sim.log; echo "simulation failed"; exit 1; }

// File: verilog/aluUnit.sv
`timescale 1ns/10ps
`default_nettype none

module aluUnit import cpuPkg::*; (
  input  aluFuncT func,
  input  logic [dataBits-1:0] a,
  input  logic [dataBits-1:0] b,
  output logic [dataBits-1:0] result
);

  logic signed [dataBits-1:0] sa;
  logic signed [dataBits-1:0] sb;

  // compares are signed
  assign sa = a;
  assign sb = b;

  always_comb begin
    case (func)
      aluEq: result = {{(dataBits-1){1'b0}}, sa == sb};
      aluLt: result = {{(dataBits-1){1'b0}}, sa < sb};
      aluLe: result = {{(dataBits-1){1'b0}}, sa <= sb};
      aluNe: result = {{(dataBits-1){1'b0}}, sa != sb};
      aluAdd: result = a + b;
      aluSub: result = a - b;
      aluAnd: result = a & b;
      aluOr: result = a | b;
      aluXor: result = a ^ b;
      aluNand: result = ~(a & b);
      aluNor: result = ~(a | b);
      aluNxor: result = ~(a ^ b);
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/cpuPkg.sv
`default_nettype none

package cpuPkg;

  // datapath sizes
  localparam int dataBits = 32;
  localparam int regNoBits = 6;
  localparam int regWords = 1 << regNoBits;
  localparam int immBits = 14;
  localparam logic [dataBits-1:0] instSize = 32'd4;
  localparam logic [dataBits-1:0] startPc = 32'h100;

  // byte address bits per memory, word index drops the low two bits
  localparam int imemAddrBits = 12;
  localparam int dmemAddrBits = 12;
  localparam int imemIdxBits = imemAddrBits - 2;
  localparam int dmemIdxBits = dmemAddrBits - 2;
  localparam int imemWords = 1 << imemIdxBits;
  localparam int dmemWords = 1 << dmemIdxBits;

  // memory-mapped devices
  localparam logic [dataBits-1:0] addrHex = 32'hFFFFF000;
  localparam logic [dataBits-1:0] addrLedr = 32'hFFFFF020;
  localparam logic [dataBits-1:0] addrSw = 32'hFFFFF090;
  localparam int hexBits = 24;
  localparam int ledrBits = 10;
  localparam int swBits = 10;
  localparam logic [hexBits-1:0] hexResetVal = 24'h123456;

  // primary opcode, instruction bits 31:26
  typedef enum logic [5:0] {
    opAlur = 6'b000000,
    opBeq  = 6'b001000,
    opBlt  = 6'b001001,
    opBle  = 6'b001010,
    opBne  = 6'b001011,
    opJal  = 6'b001100,
    opLw   = 6'b010010,
    opSw   = 6'b011010,
    opAddi = 6'b100000,
    opAndi = 6'b100100,
    opOri  = 6'b100101,
    opXori = 6'b100110
  } opcode1T;

  // secondary opcode, shares encodings with the primary ones
  typedef enum logic [5:0] {
    aluNop  = 6'b000000,
    aluEq   = 6'b001000,
    aluLt   = 6'b001001,
    aluLe   = 6'b001010,
    aluNe   = 6'b001011,
    aluJalr = 6'b001100,
    aluAdd  = 6'b100000,
    aluAnd  = 6'b100100,
    aluOr   = 6'b100101,
    aluXor  = 6'b100110,
    aluSub  = 6'b101000,
    aluNand = 6'b101100,
    aluNor  = 6'b101101,
    aluNxor = 6'b101110
  } aluFuncT;

  typedef struct packed {
    logic [dataBits-1:0] pcPlus;
    logic [dataBits-1:0] inst;
  } fetchToDecodeT;

  typedef struct packed {
    logic [dataBits-1:0] pcPlus;
    logic [dataBits-1:0] regVal1;
    logic [dataBits-1:0] regVal2;
    logic [dataBits-1:0] off;
    aluFuncT aluFunc;
    logic aluImm;
    logic isBranch;
    logic isJump;
    logic wrMem;
    logic selAluOut;
    logic selMemOut;
    logic selPcPlus;
    logic wrReg;
    logic [regNoBits-1:0] wRegNo;
  } decodeToExecT;

  typedef struct packed {
    logic [dataBits-1:0] pcPlus;
    logic [dataBits-1:0] aluOut;
    logic [dataBits-1:0] brTarg;
    logic [dataBits-1:0] jmpTarg;
    logic [dataBits-1:0] storeVal;
    logic doBranch;
    logic isJump;
    logic wrMem;
    logic selAluOut;
    logic selMemOut;
    logic selPcPlus;
    logic wrReg;
    logic [regNoBits-1:0] wRegNo;
  } execToMemT;

  typedef struct packed {
    logic wrReg;
    logic [regNoBits-1:0] wRegNo;
    logic [dataBits-1:0] wRegVal;
  } memToWbT;

endpackage

`default_nettype wire

// File: verilog/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop import cpuPkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic progWrEn,
  input  logic [imemIdxBits-1:0] progAddr,
  input  logic [dataBits-1:0] progData,
  input  logic [swBits-1:0] sw,
  output logic [hexBits-1:0] hex,
  output logic [ledrBits-1:0] ledr
);

  fetchToDecodeT fetchToDecode;
  decodeToExecT decodeToExec;
  execToMemT execToMem;
  memToWbT memToWb;
  logic stall;
  logic redirect;
  logic [dataBits-1:0] redirectPc;

  fetchStage fetch (
    .clk(clk),
    .reset(reset),
    .progWrEn(progWrEn),
    .progAddr(progAddr),
    .progData(progData),
    .stall(stall),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .fetchOut(fetchToDecode)
  );

  decodeStage decode (
    .clk(clk),
    .reset(reset),
    .fetchIn(fetchToDecode),
    .stall(stall),
    .redirect(redirect),
    .memIn(execToMem),
    .wbIn(memToWb),
    .decodeOut(decodeToExec)
  );

  executeStage execute (
    .clk(clk),
    .reset(reset),
    .decodeIn(decodeToExec),
    .redirect(redirect),
    .execOut(execToMem)
  );

  // memory stage also resolves control flow
  memoryStage memory (
    .clk(clk),
    .reset(reset),
    .execIn(execToMem),
    .sw(sw),
    .redirect(redirect),
    .redirectPc(redirectPc),
    .wbOut(memToWb),
    .hex(hex),
    .ledr(ledr)
  );

endmodule

`default_nettype wire

// File: verilog/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import cpuPkg::*; (
  input  logic clk,
  input  logic reset,
  input  fetchToDecodeT fetchIn,
  output logic stall,
  input  logic redirect,
  input  execToMemT memIn,
  input  memToWbT wbIn,
  output decodeToExecT decodeOut
);

  opcode1T op1;
  aluFuncT op2;
  logic [regNoBits-1:0] rs;
  logic [regNoBits-1:0] rt;
  logic [regNoBits-1:0] rd;
  logic [immBits-1:0] rawImm;
  logic [dataBits-1:0] regs [regWords];
  logic hitExec;
  logic hitMem;
  logic hitWb;
  decodeToExecT dec;

  // instruction fields
  assign op1 = opcode1T'(fetchIn.inst[31:26]);
  assign rs = fetchIn.inst[25:20];
  assign rt = fetchIn.inst[19:14];
  assign rd = fetchIn.inst[13:8];
  assign op2 = aluFuncT'(fetchIn.inst[5:0]);
  assign rawImm = fetchIn.inst[immBits-1:0];

  // register file, written at the end of writeback
  always_ff @(posedge clk) begin
    if (wbIn.wrReg) begin
      regs[wbIn.wRegNo] <= wbIn.wRegVal;
    end
  end

  always_comb begin
    dec = '0;
    dec.pcPlus = fetchIn.pcPlus;
    dec.regVal1 = regs[rs];
    dec.regVal2 = regs[rt];
    dec.off = {{(dataBits-immBits){rawImm[immBits-1]}}, rawImm};
    case (op1)
      opAlur: begin
        case (op2)
          aluEq, aluLt, aluLe, aluNe, aluAdd, aluAnd, aluOr, aluXor,
          aluSub, aluNand, aluNor, aluNxor: begin
            dec.aluFunc = op2;
            dec.selAluOut = 1'b1;
            dec.wRegNo = rd;
            dec.wrReg = 1'b1;
          end
          // jalr through alur is not implemented here
          aluNop, aluJalr: ;
          default: ;
        endcase
      end
      opAddi, opAndi, opOri, opXori: begin
        dec.aluImm = 1'b1;
        case (op1)
          opAddi: dec.aluFunc = aluAdd;
          opAndi: dec.aluFunc = aluAnd;
          opOri: dec.aluFunc = aluOr;
          default: dec.aluFunc = aluXor;
        endcase
        dec.selAluOut = 1'b1;
        dec.wRegNo = rt;
        dec.wrReg = 1'b1;
      end
      opBeq, opBlt, opBle, opBne: begin
        case (op1)
          opBeq: dec.aluFunc = aluEq;
          opBlt: dec.aluFunc = aluLt;
          opBle: dec.aluFunc = aluLe;
          default: dec.aluFunc = aluNe;
        endcase
        dec.isBranch = 1'b1;
      end
      opJal: begin
        // link value is the return address
        dec.isJump = 1'b1;
        dec.selPcPlus = 1'b1;
        dec.wRegNo = rt;
        dec.wrReg = 1'b1;
      end
      opLw: begin
        dec.aluImm = 1'b1;
        dec.aluFunc = aluAdd;
        dec.selMemOut = 1'b1;
        dec.wRegNo = rt;
        dec.wrReg = 1'b1;
      end
      opSw: begin
        dec.aluImm = 1'b1;
        dec.aluFunc = aluAdd;
        dec.wrMem = 1'b1;
      end
      // undefined opcodes fall through as nop
      default: ;
    endcase
  end

  // hold while any older writer targets a source register
  assign hitExec = decodeOut.wrReg && (decodeOut.wRegNo == rs || decodeOut.wRegNo == rt);
  assign hitMem = memIn.wrReg && (memIn.wRegNo == rs || memIn.wRegNo == rt);
  assign hitWb = wbIn.wrReg && (wbIn.wRegNo == rs || wbIn.wRegNo == rt);
  assign stall = hitExec || hitMem || hitWb;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      decodeOut <= '0;
    end else if (redirect || stall) begin
      decodeOut <= '0;
    end else begin
      decodeOut <= dec;
    end
  end

  // a store never also writes a register
  noStoreAndWrite: assert property (@(posedge clk) disable iff (reset)
    decodeOut.wrMem |-> !decodeOut.wrReg)
    else $error("instruction both stores and writes a register");

endmodule

`default_nettype wire

// File: verilog/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage import cpuPkg::*; (
  input  logic clk,
  input  logic reset,
  input  decodeToExecT decodeIn,
  input  logic redirect,
  output execToMemT execOut
);

  logic [dataBits-1:0] aluIn2;
  logic [dataBits-1:0] aluOut;
  logic [dataBits-1:0] offWords;
  logic [dataBits-1:0] brTarg;
  logic [dataBits-1:0] jmpTarg;
  logic doBranch;

  assign aluIn2 = decodeIn.aluImm ? decodeIn.off : decodeIn.regVal2;

  aluUnit alu (
    .func(decodeIn.aluFunc),
    .a(decodeIn.regVal1),
    .b(aluIn2),
    .result(aluOut)
  );

  // offsets count words
  assign offWords = decodeIn.off << 2;
  assign brTarg = decodeIn.pcPlus + offWords;
  assign jmpTarg = decodeIn.regVal1 + offWords;
  assign doBranch = decodeIn.isBranch && aluOut[0];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      execOut <= '0;
    end else if (redirect) begin
      execOut <= '0;
    end else begin
      execOut.pcPlus <= decodeIn.pcPlus;
      execOut.aluOut <= aluOut;
      execOut.brTarg <= brTarg;
      execOut.jmpTarg <= jmpTarg;
      execOut.storeVal <= decodeIn.regVal2;
      execOut.doBranch <= doBranch;
      execOut.isJump <= decodeIn.isJump;
      execOut.wrMem <= decodeIn.wrMem;
      execOut.selAluOut <= decodeIn.selAluOut;
      execOut.selMemOut <= decodeIn.selMemOut;
      execOut.selPcPlus <= decodeIn.selPcPlus;
      execOut.wrReg <= decodeIn.wrReg;
      execOut.wRegNo <= decodeIn.wRegNo;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage import cpuPkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic progWrEn,
  input  logic [imemIdxBits-1:0] progAddr,
  input  logic [dataBits-1:0] progData,
  input  logic stall,
  input  logic redirect,
  input  logic [dataBits-1:0] redirectPc,
  output fetchToDecodeT fetchOut
);

  logic [dataBits-1:0] pc;
  logic [dataBits-1:0] pcPlus;
  logic [dataBits-1:0] inst;
  logic [dataBits-1:0] imem [imemWords];

  // program load port, only driven while the core is held in reset
  always_ff @(posedge clk) begin
    if (progWrEn) begin
      imem[progAddr] <= progData;
    end
  end

  assign pcPlus = pc + instSize;
  assign inst = imem[pc[imemAddrBits-1:2]];

  // redirect wins over stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      pc <= startPc;
      fetchOut <= '0;
    end else if (redirect) begin
      pc <= redirectPc;
      fetchOut <= '0;
    end else if (!stall) begin
      pc <= pcPlus;
      fetchOut.pcPlus <= pcPlus;
      fetchOut.inst <= inst;
    end
  end

  // loading while running would corrupt fetched words
  progLoadInReset: assert property (@(posedge clk) progWrEn |-> reset)
    else $error("program load port written outside reset");

endmodule

`default_nettype wire

// File: verilog/memoryStage.sv
`timescale 1ns/10ps
`default_nettype none

module memoryStage import cpuPkg::*; (
  input  logic clk,
  input  logic reset,
  input  execToMemT execIn,
  input  logic [swBits-1:0] sw,
  output logic redirect,
  output logic [dataBits-1:0] redirectPc,
  output memToWbT wbOut,
  output logic [hexBits-1:0] hex,
  output logic [ledrBits-1:0] ledr
);

  logic [dataBits-1:0] memAddr;
  logic dmemSel;
  logic [dmemIdxBits-1:0] dmemIdx;
  logic [dataBits-1:0] dmem [dmemWords];
  logic [dataBits-1:0] memOut;
  logic [dataBits-1:0] wRegVal;

  assign memAddr = execIn.aluOut;
  // low addresses hit data memory
  assign dmemSel = (memAddr[dataBits-1:dmemAddrBits] == '0);
  assign dmemIdx = memAddr[dmemAddrBits-1:2];

  always_ff @(posedge clk) begin
    if (execIn.wrMem && dmemSel) begin
      dmem[dmemIdx] <= execIn.storeVal;
    end
  end

  // output registers
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hex <= hexResetVal;
      ledr <= '0;
    end else if (execIn.wrMem) begin
      if (memAddr == addrHex) begin
        hex <= execIn.storeVal[hexBits-1:0];
      end
      if (memAddr == addrLedr) begin
        ledr <= execIn.storeVal[ledrBits-1:0];
      end
    end
  end

  // unmapped addresses read as 0
  always_comb begin
    if (dmemSel) begin
      memOut = dmem[dmemIdx];
    end else if (memAddr == addrHex) begin
      memOut = {{(dataBits-hexBits){1'b0}}, hex};
    end else if (memAddr == addrLedr) begin
      memOut = {{(dataBits-ledrBits){1'b0}}, ledr};
    end else if (memAddr == addrSw) begin
      memOut = {{(dataBits-swBits){1'b0}}, sw};
    end else begin
      memOut = '0;
    end
  end

  assign redirect = execIn.doBranch || execIn.isJump;
  assign redirectPc = execIn.doBranch ? execIn.brTarg : execIn.jmpTarg;

  assign wRegVal = execIn.selAluOut ? execIn.aluOut :
                   execIn.selMemOut ? memOut :
                   execIn.selPcPlus ? execIn.pcPlus :
                   '0;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wbOut <= '0;
    end else begin
      wbOut.wrReg <= execIn.wrReg;
      wbOut.wRegNo <= execIn.wRegNo;
      wbOut.wRegVal <= wRegVal;
    end
  end

  // the ALU stage behind a redirect is squashed
  redirectFlushes: assert property (@(posedge clk) disable iff (reset)
    redirect |=> (execIn == '0))
    else $error("redirect without a bubble entering the memory stage");

endmodule

`default_nettype wire
